//--- vertex_pagerank.f
+incdir+source
source/pagerank_pkg.sv
source/read_return_if.sv
source/fifo.sv
source/edge_job_control.sv
source/cu_vertex_pagerank.sv
source/pagerank_cu_top.sv
verification/pagerank_checker.sv
verification/tb_pagerank_cu.sv

//--- verification/pagerank_testdata.txt
# V vertex_id edge_start out_degree (hex)
# M edge_index_or_tag kind payload (hex) where kind 1 fills the edge array and others go between vertices
M 0000 1 00050011
M 0001 1 00070022
M 0002 1 000a0033
V 0001 0000 0003
M 0021 2 3f800000
M 0022 3 deadbeef
V 0002 0003 0000
M 0003 1 00010101
M 0004 1 00020202
M 0005 1 00030303
M 0006 1 00040404
M 0007 1 00050505
M 0008 1 00060606
M 0009 1 00070707
M 000a 1 00080808
M 000b 1 00090909
V 0003 0003 0009
M 0030 0 12345678
M 0031 2 40490fdb
V 0004 0001 0002
M 0032 2 3e4ccccd

//--- verification/tb_pagerank_cu.sv
`default_nettype none

`include "pagerank_macros.svh"

module tb_pagerank_cu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS = 256;
	localparam int MAX_VERTS = 64;
	localparam int MAX_INJ = 32;

	logic                       clock;
	logic                       rstn;
	logic                       vertex_job_valid;
	logic [`PR_VERTEX_BITS-1:0] vertex_id;
	logic [`PR_EDGE_BITS-1:0]   vertex_edge_start;
	logic [`PR_EDGE_BITS-1:0]   vertex_out_degree;
	logic                       vertex_job_request;
	logic                       read_cmd_valid;
	logic [1:0]                 read_cmd_kind;
	logic [`PR_EDGE_BITS-1:0]   read_cmd_addr;
	logic [`PR_TAG_BITS-1:0]    read_cmd_tag;
	logic                       read_cmd_stall;
	logic                       read_rtn_valid;
	logic [1:0]                 read_rtn_kind;
	logic [`PR_TAG_BITS-1:0]    read_rtn_tag;
	logic [`PR_DATA_BITS-1:0]   read_rtn_data;
	logic                       edge_valid;
	logic [`PR_VERTEX_BITS-1:0] edge_src;
	logic [`PR_VERTEX_BITS-1:0] edge_dest;
	logic [`PR_WEIGHT_BITS-1:0] edge_weight;
	logic                       graph_valid;
	logic [`PR_TAG_BITS-1:0]    graph_tag;
	logic [`PR_DATA_BITS-1:0]   graph_rank;
	logic [`PR_VERTEX_BITS-1:0] vertex_num_counter;
	logic [`PR_EDGE_BITS-1:0]   edge_num_counter;
	logic                       run_done;
	int                         check_count;
	int                         error_count;

	// edge array image and file contents
	logic [`PR_DATA_BITS-1:0]   edge_mem [MEM_WORDS];
	logic [`PR_VERTEX_BITS-1:0] v_id [MAX_VERTS];
	logic [`PR_EDGE_BITS-1:0]   v_start [MAX_VERTS];
	logic [`PR_EDGE_BITS-1:0]   v_deg [MAX_VERTS];
	logic [1:0]                 inj_kind [MAX_INJ];
	logic [`PR_TAG_BITS-1:0]    inj_tag [MAX_INJ];
	logic [`PR_DATA_BITS-1:0]   inj_data [MAX_INJ];
	int                         inj_slot [MAX_INJ];
	int                         n_verts = 0;
	int                         n_inj = 0;
	int                         total_edges = 0;

	// pending returns of the memory model, in issue order
	logic [1:0]                 rtn_kind [$];
	logic [`PR_TAG_BITS-1:0]    rtn_tag [$];
	logic [`PR_DATA_BITS-1:0]   rtn_data [$];
	int                         rtn_due [$];
	int                         last_due = 0;
	int                         cycle = 0;
	int                         cycle_limit = 0;
	integer                     seed = 2330;

	pagerank_cu_top i_dut (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_job_valid  (vertex_job_valid),
		.vertex_id         (vertex_id),
		.vertex_edge_start (vertex_edge_start),
		.vertex_out_degree (vertex_out_degree),
		.vertex_job_request(vertex_job_request),
		.read_cmd_valid    (read_cmd_valid),
		.read_cmd_kind     (read_cmd_kind),
		.read_cmd_addr     (read_cmd_addr),
		.read_cmd_tag      (read_cmd_tag),
		.read_cmd_stall    (read_cmd_stall),
		.read_rtn_valid    (read_rtn_valid),
		.read_rtn_kind     (read_rtn_kind),
		.read_rtn_tag      (read_rtn_tag),
		.read_rtn_data     (read_rtn_data),
		.edge_valid        (edge_valid),
		.edge_src          (edge_src),
		.edge_dest         (edge_dest),
		.edge_weight       (edge_weight),
		.graph_valid       (graph_valid),
		.graph_tag         (graph_tag),
		.graph_rank        (graph_rank),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter)
	);

	pagerank_checker i_checker (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_job_valid  (vertex_job_valid),
		.vertex_id         (vertex_id),
		.vertex_edge_start (vertex_edge_start),
		.vertex_out_degree (vertex_out_degree),
		.vertex_job_request(vertex_job_request),
		.read_cmd_valid    (read_cmd_valid),
		.read_cmd_kind     (read_cmd_kind),
		.read_cmd_addr     (read_cmd_addr),
		.read_cmd_tag      (read_cmd_tag),
		.read_cmd_stall    (read_cmd_stall),
		.read_rtn_valid    (read_rtn_valid),
		.read_rtn_kind     (read_rtn_kind),
		.read_rtn_tag      (read_rtn_tag),
		.read_rtn_data     (read_rtn_data),
		.edge_valid        (edge_valid),
		.edge_src          (edge_src),
		.edge_dest         (edge_dest),
		.edge_weight       (edge_weight),
		.graph_valid       (graph_valid),
		.graph_tag         (graph_tag),
		.graph_rank        (graph_rank),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter),
		.expected_vertices (n_verts),
		.expected_edges    (total_edges),
		.run_done          (run_done),
		.check_count       (check_count),
		.error_count       (error_count)
	);

	always #10 clock = ~clock;

	task automatic read_data_file(output bit opened);
		int                       fd;
		int                       fields;
		string                    line;
		byte                      code;
		logic [31:0]              a;
		logic [31:0]              b;
		logic [31:0]              c;
		// background pattern for unused edge words
		for (int i = 0; i < MEM_WORDS; i++) begin
			edge_mem[i] = {16'(i) ^ 16'hc3c3, ~16'(i)};
		end
		fd = $fopen("verification/pagerank_testdata.txt", "r");
		opened = (fd != 0);
		if (opened) begin
			while (!$feof(fd)) begin
				line = "";
				fields = $fgets(line, fd);
				if (fields > 0 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%c %h %h %h", code, a, b, c);
					if (fields == 4 && code == "V" && n_verts < MAX_VERTS) begin
						v_id[n_verts] = a[`PR_VERTEX_BITS-1:0];
						v_start[n_verts] = b[`PR_EDGE_BITS-1:0];
						v_deg[n_verts] = c[`PR_EDGE_BITS-1:0];
						total_edges += c[`PR_EDGE_BITS-1:0];
						n_verts++;
					end else if (fields == 4 && code == "M") begin
						if (b[1:0] == pagerank_pkg::EDGE_ARRAY) begin
							edge_mem[a % MEM_WORDS] = c;
						end else if (n_inj < MAX_INJ) begin
							// goes out before the next vertex in the file
							inj_kind[n_inj] = b[1:0];
							inj_tag[n_inj] = a[`PR_TAG_BITS-1:0];
							inj_data[n_inj] = c;
							inj_slot[n_inj] = n_verts;
							n_inj++;
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic queue_return(input logic [1:0] kind, input logic [`PR_TAG_BITS-1:0] tag,
		input logic [`PR_DATA_BITS-1:0] data, input int delay);
		int due;
		due = cycle + delay;
		// one return per cycle keeps issue order
		if (due <= last_due) begin
			due = last_due + 1;
		end
		last_due = due;
		rtn_kind.push_back(kind);
		rtn_tag.push_back(tag);
		rtn_data.push_back(data);
		rtn_due.push_back(due);
	endtask

	task automatic wait_idle();
		while (rtn_due.size() != 0 || !vertex_job_request) begin
			@(posedge clock);
			#2;
		end
	endtask

	////////////////////////////////////////
	// memory model, stall and timeout
	////////////////////////////////////////

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			if (rstn && read_cmd_valid && !read_cmd_stall) begin
				queue_return(pagerank_pkg::EDGE_ARRAY, read_cmd_tag,
					edge_mem[read_cmd_addr % MEM_WORDS], 1 + ({$random(seed)} % 3));
			end
			#2;
			read_cmd_stall = rstn && ({$random(seed)} % 4 == 0);
			if (rtn_due.size() != 0 && rtn_due[0] <= cycle) begin
				read_rtn_valid = 1'b1;
				read_rtn_kind = rtn_kind.pop_front();
				read_rtn_tag = rtn_tag.pop_front();
				read_rtn_data = rtn_data.pop_front();
				void'(rtn_due.pop_front());
			end else begin
				read_rtn_valid = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// vertex driver
	////////////////////////////////////////

	initial begin
		bit opened;
		clock = 1'b0;
		rstn = 1'b0;
		vertex_job_valid = 1'b0;
		vertex_id = '0;
		vertex_edge_start = '0;
		vertex_out_degree = '0;
		read_cmd_stall = 1'b0;
		read_rtn_valid = 1'b0;
		read_rtn_kind = '0;
		read_rtn_tag = '0;
		read_rtn_data = '0;
		run_done = 1'b0;
		read_data_file(opened);
		if (!opened) begin
			$display("could not open verification/pagerank_testdata.txt");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			cycle_limit = 20 * total_edges + 50 * n_verts + 200;
			repeat (10) @(posedge clock);
			#2;
			rstn = 1'b1;
			for (int v = 0; v <= n_verts; v++) begin
				wait_idle();
				// graph and unknown-tag words between vertices
				for (int w = 0; w < n_inj; w++) begin
					if (inj_slot[w] == v) begin
						queue_return(inj_kind[w], inj_tag[w], inj_data[w], 1);
						@(posedge clock);
						#2;
					end
				end
				if (v < n_verts) begin
					wait_idle();
					vertex_job_valid = 1'b1;
					vertex_id = v_id[v];
					vertex_edge_start = v_start[v];
					vertex_out_degree = v_deg[v];
					@(posedge clock);
					#2;
					vertex_job_valid = 1'b0;
				end
			end
			wait_idle();
			repeat (10) @(posedge clock);
			#2;
			run_done = 1'b1;
			@(posedge clock);
			#1;
			$display("checks: %0d  errors: %0d", check_count, error_count);
			if (error_count == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verification/pagerank_checker.sv
`default_nettype none

`include "pagerank_macros.svh"

module pagerank_checker (
	input  wire logic                       clock,
	input  wire logic                       rstn,
	input  wire logic                       vertex_job_valid,
	input  wire logic [`PR_VERTEX_BITS-1:0] vertex_id,
	input  wire logic [`PR_EDGE_BITS-1:0]   vertex_edge_start,
	input  wire logic [`PR_EDGE_BITS-1:0]   vertex_out_degree,
	input  wire logic                       vertex_job_request,
	input  wire logic                       read_cmd_valid,
	input  wire logic [1:0]                 read_cmd_kind,
	input  wire logic [`PR_EDGE_BITS-1:0]   read_cmd_addr,
	input  wire logic [`PR_TAG_BITS-1:0]    read_cmd_tag,
	input  wire logic                       read_cmd_stall,
	input  wire logic                       read_rtn_valid,
	input  wire logic [1:0]                 read_rtn_kind,
	input  wire logic [`PR_TAG_BITS-1:0]    read_rtn_tag,
	input  wire logic [`PR_DATA_BITS-1:0]   read_rtn_data,
	input  wire logic                       edge_valid,
	input  wire logic [`PR_VERTEX_BITS-1:0] edge_src,
	input  wire logic [`PR_VERTEX_BITS-1:0] edge_dest,
	input  wire logic [`PR_WEIGHT_BITS-1:0] edge_weight,
	input  wire logic                       graph_valid,
	input  wire logic [`PR_TAG_BITS-1:0]    graph_tag,
	input  wire logic [`PR_DATA_BITS-1:0]   graph_rank,
	input  wire logic [`PR_VERTEX_BITS-1:0] vertex_num_counter,
	input  wire logic [`PR_EDGE_BITS-1:0]   edge_num_counter,
	input  wire logic [31:0]                expected_vertices,
	input  wire logic [31:0]                expected_edges,
	input  wire logic                       run_done,
	output int                              check_count,
	output int                              error_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic                        after_reset = 1'b0;
	logic                        active = 1'b0;
	logic [`PR_VERTEX_BITS-1:0]  cur_id = '0;
	logic [`PR_EDGE_BITS-1:0]    cur_start = '0;
	int                          cur_deg = 0;
	int                          cmd_k = 0;
	int                          edge_k = 0;
	int                          outstanding = 0;
	int                          accepted = 0;
	logic                        prev_stalled = 1'b0;
	logic [`PR_EDGE_BITS-1:0]    prev_addr = '0;
	logic [`PR_TAG_BITS-1:0]     prev_tag = '0;
	logic [`PR_DATA_BITS-1:0]    word;
	logic [`PR_TAG_BITS-1:0]     graph_tags [$];
	logic [`PR_DATA_BITS-1:0]    graph_ranks [$];

	initial begin
		check_count = 0;
		error_count = 0;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_fault(input string what);
		check_count++;
		error_count++;
		$display("** Error at %0t ns: %s", $time, what);
	endtask

	////////////////////////////////////////
	// per cycle port checks
	////////////////////////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				check_value("vertex request after reset", vertex_job_request, 1);
				check_value("command valid after reset", read_cmd_valid, 0);
				check_value("edge valid after reset", edge_valid, 0);
				check_value("graph valid after reset", graph_valid, 0);
				after_reset = 1'b0;
			end
			// a stalled command has to stay put
			if (prev_stalled) begin
				check_value("held command valid", read_cmd_valid, 1);
				check_value("held command address", read_cmd_addr, prev_addr);
				check_value("held command tag", read_cmd_tag, prev_tag);
			end
			prev_stalled = read_cmd_valid & read_cmd_stall;
			prev_addr = read_cmd_addr;
			prev_tag = read_cmd_tag;

			if (read_cmd_valid && !read_cmd_stall) begin
				if (!active || cmd_k >= cur_deg) begin
					report_fault("read command issued with no edge left to read");
				end else begin
					check_value("command address", read_cmd_addr, cur_start + cmd_k);
					check_value("command kind", read_cmd_kind, pagerank_pkg::EDGE_ARRAY);
					check_value("command tag", read_cmd_tag, cmd_k[`PR_TAG_BITS-1:0]);
				end
				cmd_k++;
				outstanding++;
			end
			// a read stays outstanding until its edge job leaves the unit
			if (edge_valid) begin
				outstanding--;
			end
			check_count++;
			if (outstanding > `PR_READ_FIFO_DEPTH) begin
				report_fault("more edge reads outstanding than the read buffer holds");
			end

			if (edge_valid) begin
				if (!active || edge_k >= cur_deg) begin
					report_fault("edge job beyond the out-degree of the vertex");
				end else begin
					// edge view of the word, destination in the upper half
					word = tb_pagerank_cu.edge_mem[cur_start + edge_k];
					check_value("edge source", edge_src, cur_id);
					check_value("edge destination", edge_dest, word[31:16]);
					check_value("edge weight", edge_weight, word[15:0]);
				end
				edge_k++;
			end

			if (graph_valid) begin
				if (graph_tags.size() == 0) begin
					report_fault("graph word on the output with none injected");
				end else begin
					check_value("graph tag", graph_tag, graph_tags.pop_front());
					check_value("graph rank", graph_rank, graph_ranks.pop_front());
				end
			end
			if (read_rtn_valid && read_rtn_kind == pagerank_pkg::GRAPH_DATA) begin
				graph_tags.push_back(read_rtn_tag);
				graph_ranks.push_back(read_rtn_data);
			end

			// request back high means the vertex is finished
			if (active && vertex_job_request) begin
				check_value("edge jobs of vertex", edge_k, cur_deg);
				check_value("read commands of vertex", cmd_k, cur_deg);
				active = 1'b0;
			end
			if (vertex_job_valid && vertex_job_request) begin
				active = 1'b1;
				cur_id = vertex_id;
				cur_start = vertex_edge_start;
				cur_deg = vertex_out_degree;
				cmd_k = 0;
				edge_k = 0;
				accepted++;
			end
		end
	end

	////////////////////////////////////////
	// end of run
	////////////////////////////////////////

	always @(posedge run_done) begin
		check_value("vertex counter", vertex_num_counter, expected_vertices);
		check_value("edge counter", edge_num_counter, expected_edges);
		check_value("accepted vertices", accepted, expected_vertices);
		if (active) begin
			report_fault("last vertex never completed");
		end
		if (graph_tags.size() != 0) begin
			report_fault("injected graph words never reached the output");
		end
	end

endmodule

`default_nettype wire

//--- source/pagerank_cu_top.sv
`default_nettype none

`include "pagerank_macros.svh"

module pagerank_cu_top (
	input  wire logic                         clock,
	input  wire logic                         rstn,
	input  wire logic                         vertex_job_valid,
	input  wire logic [`PR_VERTEX_BITS-1:0]   vertex_id,
	input  wire logic [`PR_EDGE_BITS-1:0]     vertex_edge_start,
	input  wire logic [`PR_EDGE_BITS-1:0]     vertex_out_degree,
	output logic                              vertex_job_request,
	output logic                              read_cmd_valid,
	output logic [1:0]                        read_cmd_kind,
	output logic [`PR_EDGE_BITS-1:0]          read_cmd_addr,
	output logic [`PR_TAG_BITS-1:0]           read_cmd_tag,
	input  wire logic                         read_cmd_stall,
	input  wire logic                         read_rtn_valid,
	input  wire logic [1:0]                   read_rtn_kind,
	input  wire logic [`PR_TAG_BITS-1:0]      read_rtn_tag,
	input  wire logic [`PR_DATA_BITS-1:0]     read_rtn_data,
	output logic                              edge_valid,
	output logic [`PR_VERTEX_BITS-1:0]        edge_src,
	output logic [`PR_VERTEX_BITS-1:0]        edge_dest,
	output logic [`PR_WEIGHT_BITS-1:0]        edge_weight,
	output logic                              graph_valid,
	output logic [`PR_TAG_BITS-1:0]           graph_tag,
	output logic [`PR_DATA_BITS-1:0]          graph_rank,
	output logic [`PR_VERTEX_BITS-1:0]        vertex_num_counter,
	output logic [`PR_EDGE_BITS-1:0]          edge_num_counter
);

	pagerank_pkg::vertex_job_t   vertex_job;
	pagerank_pkg::read_return_t  read_return;
	pagerank_pkg::read_command_t read_command;
	pagerank_pkg::edge_job_t     edge_job;

	// pack incoming fields
	assign vertex_job = '{
		valid:      vertex_job_valid,
		id:         vertex_id,
		edge_start: vertex_edge_start,
		out_degree: vertex_out_degree
	};

	assign read_return = '{
		valid: read_rtn_valid,
		kind:  pagerank_pkg::struct_kind_e'(read_rtn_kind),
		tag:   read_rtn_tag,
		word:  read_rtn_data
	};

	// unpack outgoing structs
	assign read_cmd_valid = read_command.valid;
	assign read_cmd_kind  = read_command.kind;
	assign read_cmd_addr  = read_command.addr;
	assign read_cmd_tag   = read_command.tag;

	assign edge_valid  = edge_job.valid;
	assign edge_src    = edge_job.src;
	assign edge_dest   = edge_job.dest;
	assign edge_weight = edge_job.weight;

	cu_vertex_pagerank i_cu_vertex_pagerank (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_job        (vertex_job),
		.vertex_job_request(vertex_job_request),
		.read_command      (read_command),
		.read_cmd_stall    (read_cmd_stall),
		.read_return       (read_return),
		.edge_job          (edge_job),
		.graph_valid       (graph_valid),
		.graph_tag         (graph_tag),
		.graph_rank        (graph_rank),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter)
	);

endmodule

`default_nettype wire

//--- source/cu_vertex_pagerank.sv
`default_nettype none

`include "pagerank_macros.svh"

module cu_vertex_pagerank (
	input  wire logic                         clock,
	input  wire logic                         rstn,
	input  wire pagerank_pkg::vertex_job_t    vertex_job,
	output logic                              vertex_job_request,
	output pagerank_pkg::read_command_t       read_command,
	input  wire logic                         read_cmd_stall,
	input  wire pagerank_pkg::read_return_t   read_return,
	output pagerank_pkg::edge_job_t           edge_job,
	output logic                              graph_valid,
	output logic [`PR_TAG_BITS-1:0]           graph_tag,
	output logic [`PR_DATA_BITS-1:0]          graph_rank,
	output logic [`PR_VERTEX_BITS-1:0]        vertex_num_counter,
	output logic [`PR_EDGE_BITS-1:0]          edge_num_counter
);

	pagerank_pkg::vertex_job_t    vertex_job_latched;
	pagerank_pkg::read_return_t   read_return_latched;
	pagerank_pkg::read_return_t   buffer_out;
	logic                         buffer_full;
	logic                         buffer_empty;
	logic                         buffer_pop;
	logic                         processing_vertex;
	logic                         vertex_accept;
	logic                         vertex_done;
	logic                         graph_steer_valid;
	logic [`PR_TAG_BITS-1:0]      graph_steer_tag;
	pagerank_pkg::read_word_u     graph_steer_word;

	read_return_if rtn_if ();

	////////////////////////////////////////
	// vertex tracking
	////////////////////////////////////////

	assign vertex_job_request = ~processing_vertex;
	assign vertex_accept      = vertex_job.valid & vertex_job_request;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_latched <= '0;
			processing_vertex  <= 1'b0;
		end else begin
			if (vertex_accept) begin
				vertex_job_latched <= vertex_job;
				processing_vertex  <= 1'b1;
			end else if (vertex_done) begin
				vertex_job_latched.valid <= 1'b0;
				processing_vertex        <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			if (vertex_accept) begin
				vertex_num_counter <= vertex_num_counter + 1'b1;
			end
			if (edge_job.valid) begin
				edge_num_counter <= edge_num_counter + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// read return buffering
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_return_latched <= '0;
		end else begin
			read_return_latched <= read_return;
		end
	end

	// drained every cycle, never back-pressured
	assign buffer_pop = ~buffer_empty;

	fifo #(
		.DEPTH(`PR_READ_FIFO_DEPTH)
	) i_read_return_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (read_return_latched.valid),
		.data_in    (read_return_latched),
		.full       (buffer_full),
		.almost_full(),
		.pop        (buffer_pop),
		.data_out   (buffer_out),
		.empty      (buffer_empty)
	);

	////////////////////////////////////////
	// tag steering
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rtn_if.valid      <= 1'b0;
			graph_steer_valid <= 1'b0;
		end else begin
			rtn_if.valid      <= 1'b0;
			graph_steer_valid <= 1'b0;
			if (buffer_pop) begin
				case (buffer_out.kind)
					pagerank_pkg::EDGE_ARRAY: rtn_if.valid <= 1'b1;
					pagerank_pkg::GRAPH_DATA: graph_steer_valid <= 1'b1;
					// none and reserved words die here
					default: begin
					end
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (buffer_pop) begin
			rtn_if.kind      <= buffer_out.kind;
			rtn_if.tag       <= buffer_out.tag;
			rtn_if.word      <= buffer_out.word;
			graph_steer_tag  <= buffer_out.tag;
			graph_steer_word <= buffer_out.word;
		end
	end

	// graph output register, rank view of the word
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			graph_valid <= 1'b0;
		end else begin
			graph_valid <= graph_steer_valid;
		end
	end

	always_ff @(posedge clock) begin
		graph_tag  <= graph_steer_tag;
		graph_rank <= graph_steer_word.rank;
	end

	edge_job_control i_edge_job_control (
		.clock         (clock),
		.rstn          (rstn),
		.vertex_job    (vertex_job_latched),
		.returns       (rtn_if),
		.read_cmd_stall(read_cmd_stall),
		.read_command  (read_command),
		.edge_job      (edge_job),
		.vertex_done   (vertex_done)
	);

	// relies on edge control capping outstanding reads
	buffer_no_overflow: assert property (
		@(posedge clock) disable iff (!rstn)
		read_return_latched.valid |-> !buffer_full
	) else $error("read return buffer pushed while full");

endmodule

`default_nettype wire

//--- source/edge_job_control.sv
`default_nettype none

`include "pagerank_macros.svh"

module edge_job_control (
	input  wire logic                         clock,
	input  wire logic                         rstn,
	input  wire pagerank_pkg::vertex_job_t    vertex_job,
	read_return_if.sink                       returns,
	input  wire logic                         read_cmd_stall,
	output pagerank_pkg::read_command_t       read_command,
	output pagerank_pkg::edge_job_t           edge_job,
	output logic                              vertex_done
);

	localparam int OUT_BITS = $clog2(`PR_READ_FIFO_DEPTH + 1);
	localparam logic [OUT_BITS-1:0] OUT_MAX = OUT_BITS'(`PR_READ_FIFO_DEPTH);

	logic [`PR_EDGE_BITS-1:0] issue_index;
	logic [`PR_EDGE_BITS-1:0] pushed_count;
	logic [OUT_BITS-1:0]      outstanding;
	logic                     cmd_issued;
	logic                     cmd_slot_free;
	logic                     cmd_load;
	logic                     edge_return;

	////////////////////////////////////////
	// read command issue
	////////////////////////////////////////

	assign cmd_issued    = read_command.valid & ~read_cmd_stall;
	assign cmd_slot_free = ~read_command.valid | cmd_issued;

	// the loaded command will itself be outstanding once it goes out
	assign cmd_load = vertex_job.valid & cmd_slot_free
		& (issue_index != vertex_job.out_degree)
		& (outstanding < OUT_MAX - OUT_BITS'(cmd_issued));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command <= '0;
			issue_index  <= '0;
		end else begin
			if (cmd_load) begin
				read_command.valid <= 1'b1;
				read_command.kind  <= pagerank_pkg::EDGE_ARRAY;
				read_command.addr  <= vertex_job.edge_start + issue_index;
				read_command.tag   <= issue_index[`PR_TAG_BITS-1:0];
				issue_index        <= issue_index + 1'b1;
			end else if (cmd_issued) begin
				read_command.valid <= 1'b0;
			end
			if (vertex_done) begin
				issue_index <= '0;
			end
		end
	end

	assign edge_return = returns.valid & (returns.kind == pagerank_pkg::EDGE_ARRAY);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + OUT_BITS'(cmd_issued) - OUT_BITS'(edge_return);
		end
	end

	////////////////////////////////////////
	// edge jobs
	////////////////////////////////////////

	// returns come back in issue order
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_job     <= '0;
			pushed_count <= '0;
		end else begin
			edge_job.valid <= edge_return;
			if (edge_return) begin
				edge_job.src    <= vertex_job.id;
				edge_job.dest   <= returns.word.edge_view.dest;
				edge_job.weight <= returns.word.edge_view.weight;
				pushed_count    <= pushed_count + 1'b1;
			end
			if (vertex_done) begin
				pushed_count <= '0;
			end
		end
	end

	// lines up with the last edge job, or first latched cycle for degree zero
	assign vertex_done = vertex_job.valid & (pushed_count == vertex_job.out_degree);

	outstanding_bound: assert property (
		@(posedge clock) disable iff (!rstn)
		outstanding <= OUT_MAX
	) else $error("outstanding edge reads above bound");

	// every return must belong to a read of the current vertex
	return_expected: assert property (
		@(posedge clock) disable iff (!rstn)
		edge_return |-> (outstanding != '0) && (returns.tag < vertex_job.out_degree)
	) else $error("edge return with no matching read");

endmodule

`default_nettype wire

//--- source/fifo.sv
`default_nettype none

module fifo #(
	parameter int DEPTH = 4
) (
	input  wire logic                         clock,
	input  wire logic                         rstn,
	input  wire logic                         push,
	input  wire pagerank_pkg::read_return_t   data_in,
	output logic                              full,
	output logic                              almost_full,
	input  wire logic                         pop,
	output pagerank_pkg::read_return_t        data_out,
	output logic                              empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	pagerank_pkg::read_return_t mem [DEPTH];
	pagerank_pkg::read_return_t head;
	logic                       head_valid;
	logic [PTR_BITS-1:0]        wr_ptr;
	logic [PTR_BITS-1:0]        rd_ptr;
	logic [CNT_BITS-1:0]        mem_count;
	logic [CNT_BITS-1:0]        level;
	logic                       do_push;
	logic                       refill;
	logic                       from_mem;
	logic                       bypass;
	logic                       to_mem;

	// head register counts as one entry
	assign level       = mem_count + CNT_BITS'(head_valid);
	assign full        = (level == CNT_BITS'(DEPTH));
	assign almost_full = (level >= CNT_BITS'(DEPTH - 1));
	assign empty       = ~head_valid;
	assign data_out    = head;

	assign do_push  = push & ~full;
	// head is free or leaves this cycle, pops on empty fall out here
	assign refill   = ~head_valid | (pop & head_valid);
	assign from_mem = refill & (mem_count != '0);
	// straight into the head when nothing is queued
	assign bypass   = refill & (mem_count == '0) & do_push;
	assign to_mem   = do_push & ~bypass;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			mem_count  <= '0;
			head_valid <= 1'b0;
		end else begin
			if (to_mem) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (from_mem) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			mem_count <= mem_count + CNT_BITS'(to_mem) - CNT_BITS'(from_mem);
			if (refill) begin
				head_valid <= from_mem | bypass;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (to_mem) begin
			mem[wr_ptr] <= data_in;
		end
		if (from_mem) begin
			head <= mem[rd_ptr];
		end else if (bypass) begin
			head <= data_in;
		end
	end

endmodule

`default_nettype wire

//--- source/read_return_if.sv
`default_nettype none

`include "pagerank_macros.svh"

// edge array returns after steering
interface read_return_if;
	logic                       valid;
	pagerank_pkg::struct_kind_e kind;
	logic [`PR_TAG_BITS-1:0]    tag;
	pagerank_pkg::read_word_u   word;

	// compute unit side
	modport source (
		output valid, kind, tag, word
	);

	// edge control side
	modport sink (
		input valid, kind, tag, word
	);
endinterface

`default_nettype wire

//--- source/pagerank_pkg.sv
`default_nettype none

`include "pagerank_macros.svh"

package pagerank_pkg;

	// structure a returned word belongs to
	typedef enum logic [1:0] {
		NONE       = 2'd0,
		EDGE_ARRAY = 2'd1,
		GRAPH_DATA = 2'd2,
		RESERVED   = 2'd3
	} struct_kind_e;

	typedef struct packed {
		logic                       valid;
		logic [`PR_VERTEX_BITS-1:0] id;
		logic [`PR_EDGE_BITS-1:0]   edge_start;
		logic [`PR_EDGE_BITS-1:0]   out_degree;
	} vertex_job_t;

	// addr is an index into the edge array
	typedef struct packed {
		logic                     valid;
		struct_kind_e             kind;
		logic [`PR_EDGE_BITS-1:0] addr;
		logic [`PR_TAG_BITS-1:0]  tag;
	} read_command_t;

	typedef struct packed {
		logic [`PR_VERTEX_BITS-1:0] dest;
		logic [`PR_WEIGHT_BITS-1:0] weight;
	} edge_word_t;

	// same word, edge view or rank view depending on the kind
	typedef union packed {
		edge_word_t               edge_view;
		logic [`PR_DATA_BITS-1:0] rank;
	} read_word_u;

	typedef struct packed {
		logic                    valid;
		struct_kind_e            kind;
		logic [`PR_TAG_BITS-1:0] tag;
		read_word_u              word;
	} read_return_t;

	typedef struct packed {
		logic                       valid;
		logic [`PR_VERTEX_BITS-1:0] src;
		logic [`PR_VERTEX_BITS-1:0] dest;
		logic [`PR_WEIGHT_BITS-1:0] weight;
	} edge_job_t;

endpackage

`default_nettype wire

//--- source/pagerank_macros.svh
`ifndef PAGERANK_MACROS_SVH
`define PAGERANK_MACROS_SVH

// vertex ids, also edge destinations
`define PR_VERTEX_BITS 16

// edge index and out-degree
`define PR_EDGE_BITS 16

// one read data word
`define PR_DATA_BITS 32
`define PR_WEIGHT_BITS (`PR_DATA_BITS - `PR_VERTEX_BITS)

`define PR_TAG_BITS 8

// read return buffer, also the cap on outstanding edge reads
`define PR_READ_FIFO_DEPTH 8

`endif
